/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_renameCore
FILELIST ?= renameCore.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* coreDefs.sv */
package coreDefs;

    // ******************************
    // sizes
    // ******************************
    localparam int regIdxWidth = 5;
    localparam int dataWidth = 32;
    localparam int tagWidth = 3;
    localparam int robEntries = 7;

    // ******************************
    // instruction encoding
    // ******************************
    localparam logic [6:0] opcodeReg = 7'b0110011;
    localparam logic [6:0] opcodeImm = 7'b0010011;

    localparam logic [2:0] funct3AddSub = 3'b000;
    localparam logic [2:0] funct3Slt = 3'b010;
    localparam logic [2:0] funct3Xor = 3'b100;
    localparam logic [2:0] funct3Or = 3'b110;
    localparam logic [2:0] funct3And = 3'b111;

    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Sub = 7'b0100000;

    // ******************************
    // ALU operations
    // ******************************
    localparam int aluOpWidth = 3;
    localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
    localparam logic [aluOpWidth-1:0] aluOr = 3'd3;
    localparam logic [aluOpWidth-1:0] aluXor = 3'd4;
    localparam logic [aluOpWidth-1:0] aluSlt = 3'd5;

    // the same word seen as register-register or register-immediate fields.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
    } instWord_u;

endpackage

/* execUnit.sv */
`timescale 1ns/1ps

module execUnit
    import coreDefs::*;
(
    input logic clk,
    input logic rst,
    input logic load,
    input logic [aluOpWidth-1:0] aluOpIn,
    input logic [dataWidth-1:0] immIn,
    input logic useImmIn,
    input logic [tagWidth-1:0] tagIn,
    input logic [dataWidth-1:0] regData1,
    input logic [dataWidth-1:0] regData2,
    input logic [tagWidth-1:0] regTag1,
    input logic [tagWidth-1:0] regTag2,
    input logic [dataWidth-1:0] robReadData1,
    input logic [dataWidth-1:0] robReadData2,
    output logic [tagWidth-1:0] robReadTag1,
    output logic [tagWidth-1:0] robReadTag2,
    output logic [tagWidth-1:0] resultTag,
    output logic [dataWidth-1:0] result
);

    logic [aluOpWidth-1:0] aluOp;
    logic [dataWidth-1:0] imm;
    logic useImm;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aluOp <= aluAdd;
            imm <= '0;
            useImm <= 1'b0;
            resultTag <= '0;
        end else if (load) begin
            aluOp <= aluOpIn;
            imm <= immIn;
            useImm <= useImmIn;
            resultTag <= tagIn;
        end
    end

    // a pending source takes its value from the producer's reorder-buffer entry.
    assign robReadTag1 = regTag1;
    assign robReadTag2 = regTag2;
    assign opA = (regTag1 != '0) ? robReadData1 : regData1;
    assign opB = useImm ? imm : ((regTag2 != '0) ? robReadData2 : regData2);

    always_comb begin
        case (aluOp)
            aluSub: result = opA - opB;
            aluAnd: result = opA & opB;
            aluOr: result = opA | opB;
            aluXor: result = opA ^ opB;
            aluSlt: result = ($signed(opA) < $signed(opB)) ? dataWidth'(1) : '0;
            default: result = opA + opB;
        endcase
    end

endmodule

/* instDecoder.sv */
`timescale 1ns/1ps

module instDecoder
    import coreDefs::*;
(
    input instWord_u instWord,
    output logic [regIdxWidth-1:0] rs1,
    output logic [regIdxWidth-1:0] rs2,
    output logic [regIdxWidth-1:0] rd,
    output logic [aluOpWidth-1:0] aluOp,
    output logic [dataWidth-1:0] imm,
    output logic useImm,
    output logic writesRd
);

    logic legalFunct7;

    // rs2 holds immediate bits for an I-type word and is simply ignored then.
    assign rs1 = instWord.r.rs1;
    assign rs2 = instWord.r.rs2;
    assign imm = {{(dataWidth - 12){instWord.i.imm12[11]}}, instWord.i.imm12};

    // an instruction without a destination retires with rd zero, so it never writes.
    assign rd = writesRd ? instWord.r.rd : '0;

    assign legalFunct7 = (instWord.r.funct7 == funct7Base) ||
                         (instWord.r.funct7 == funct7Sub && instWord.r.funct3 == funct3AddSub);

    always_comb begin
        aluOp = aluAdd;
        useImm = 1'b0;
        writesRd = 1'b0;
        case (instWord.r.opcode)
            opcodeReg: begin
                writesRd = legalFunct7;
                case (instWord.r.funct3)
                    funct3AddSub: aluOp = (instWord.r.funct7 == funct7Sub) ? aluSub : aluAdd;
                    funct3Slt: aluOp = aluSlt;
                    funct3Xor: aluOp = aluXor;
                    funct3Or: aluOp = aluOr;
                    funct3And: aluOp = aluAnd;
                    default: writesRd = 1'b0;
                endcase
            end
            opcodeImm: begin
                useImm = 1'b1;
                writesRd = 1'b1;
                case (instWord.i.funct3)
                    funct3AddSub: aluOp = aluAdd;
                    funct3Slt: aluOp = aluSlt;
                    funct3Xor: aluOp = aluXor;
                    funct3Or: aluOp = aluOr;
                    funct3And: aluOp = aluAnd;
                    default: writesRd = 1'b0;
                endcase
            end
            default: begin
                writesRd = 1'b0;
            end
        endcase
    end

endmodule

/* issueControl.sv */
`timescale 1ns/1ps

module issueControl (
    input logic clk,
    input logic rst,
    input logic instValid,
    input logic flush,
    input logic commitHold,
    input logic robFull,
    input logic headReady,
    input logic writesRd,
    output logic accept,
    output logic renameEn,
    output logic instStall,
    output logic resultWrite,
    output logic retire
);

    logic execValid;

    // ******************************
    // issue side
    // ******************************
    // the stall is a plain level, high while every entry is taken.
    assign instStall = robFull;

    // an instruction seen during a flush is dropped.
    assign accept = instValid && !robFull && !flush;

    // only instructions with a destination touch the tag map.
    assign renameEn = accept && writesRd;

    // accept is already low during a flush, so this also empties the stage.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            execValid <= 1'b0;
        end else begin
            execValid <= accept;
        end
    end

    // ******************************
    // completion and retire
    // ******************************
    // a flush squashes the instruction in execute before it reaches the buffer.
    assign resultWrite = execValid && !flush;

    // retire stops under back-pressure and during a flush.
    assign retire = headReady && !commitHold && !flush;

    // a head entry only turns ready through a result written at the edge before.
    headReadyAfterWrite: assert property (@(posedge clk) disable iff (rst)
        $rose(headReady) |-> $past(resultWrite))
        else $error("head became ready without a result write");

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile
    import coreDefs::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic renameEn,
    input logic [regIdxWidth-1:0] renameRd,
    input logic [tagWidth-1:0] renameTag,
    input logic retireEn,
    input logic [regIdxWidth-1:0] retireRd,
    input logic [tagWidth-1:0] retireTag,
    input logic [dataWidth-1:0] retireData,
    input logic [regIdxWidth-1:0] readIdx1,
    input logic [regIdxWidth-1:0] readIdx2,
    output logic [dataWidth-1:0] readData1,
    output logic [dataWidth-1:0] readData2,
    output logic [tagWidth-1:0] readTag1,
    output logic [tagWidth-1:0] readTag2
);

    localparam int regCount = 2 ** regIdxWidth;

    logic [dataWidth-1:0] regs [regCount];
    logic [tagWidth-1:0] tags [regCount];

    logic retireWrite;
    logic retireClear;
    logic renameHit;

    // register zero is never written or tagged.
    assign retireWrite = retireEn && (retireRd != '0);
    assign retireClear = retireWrite && (tags[retireRd] == retireTag);
    assign renameHit = renameEn && (renameRd != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < regCount; k++) begin
                regs[k] <= '0;
            end
        end else if (retireWrite) begin
            regs[retireRd] <= retireData;
        end
    end

    // the rename comes last, so it overrides a clear of the same register.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < regCount; k++) begin
                tags[k] <= '0;
            end
        end else if (flush) begin
            for (int k = 0; k < regCount; k++) begin
                tags[k] <= '0;
            end
        end else begin
            if (retireClear) begin
                tags[retireRd] <= '0;
            end
            if (renameHit) begin
                tags[renameRd] <= renameTag;
            end
        end
    end

    // ******************************
    // read ports
    // ******************************
    // the sources belong to the instruction being renamed, so they see the tags
    // from before its own rename; a retire in the same cycle is forwarded.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readTag1 <= '0;
            readTag2 <= '0;
        end else begin
            if (flush || (retireClear && retireRd == readIdx1)) begin
                readTag1 <= '0;
            end else begin
                readTag1 <= tags[readIdx1];
            end
            if (flush || (retireClear && retireRd == readIdx2)) begin
                readTag2 <= '0;
            end else begin
                readTag2 <= tags[readIdx2];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readData1 <= '0;
            readData2 <= '0;
        end else begin
            readData1 <= (retireWrite && retireRd == readIdx1) ? retireData : regs[readIdx1];
            readData2 <= (retireWrite && retireRd == readIdx2) ? retireData : regs[readIdx2];
        end
    end

    renameTagNonZero: assert property (@(posedge clk) disable iff (rst)
        renameEn |-> renameTag != '0)
        else $error("rename issued with tag zero");

endmodule

/* renameCore.f */
coreDefs.sv
instDecoder.sv
regFile.sv
reorderBuffer.sv
execUnit.sv
issueControl.sv
renameCore.sv
tb_renameCore.sv

/* renameCore.sv */
`timescale 1ns/1ps

module renameCore
    import coreDefs::*;
(
    input logic clk,
    input logic rst,
    input logic instValid,
    input logic [dataWidth-1:0] instWord,
    input logic flush,
    input logic commitHold,
    output logic instStall,
    output logic commitValid,
    output logic [regIdxWidth-1:0] commitRd,
    output logic [dataWidth-1:0] commitData
);

    logic [regIdxWidth-1:0] rs1;
    logic [regIdxWidth-1:0] rs2;
    logic [regIdxWidth-1:0] rd;
    logic [aluOpWidth-1:0] aluOp;
    logic [dataWidth-1:0] imm;
    logic useImm;
    logic writesRd;

    logic accept;
    logic renameEn;
    logic resultWrite;
    logic robFull;
    logic headReady;
    logic [tagWidth-1:0] allocTag;
    logic [tagWidth-1:0] headTag;

    logic [dataWidth-1:0] readData1;
    logic [dataWidth-1:0] readData2;
    logic [tagWidth-1:0] readTag1;
    logic [tagWidth-1:0] readTag2;
    logic [tagWidth-1:0] robReadTag1;
    logic [tagWidth-1:0] robReadTag2;
    logic [dataWidth-1:0] robReadData1;
    logic [dataWidth-1:0] robReadData2;
    logic [tagWidth-1:0] resultTag;
    logic [dataWidth-1:0] result;

    instDecoder i_instDecoder (
        .instWord(instWord),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .aluOp(aluOp),
        .imm(imm),
        .useImm(useImm),
        .writesRd(writesRd)
    );

    // the retiring head entry is also the commit report.
    regFile i_regFile (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .renameEn(renameEn),
        .renameRd(rd),
        .renameTag(allocTag),
        .retireEn(commitValid),
        .retireRd(commitRd),
        .retireTag(headTag),
        .retireData(commitData),
        .readIdx1(rs1),
        .readIdx2(rs2),
        .readData1(readData1),
        .readData2(readData2),
        .readTag1(readTag1),
        .readTag2(readTag2)
    );

    reorderBuffer i_reorderBuffer (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .alloc(accept),
        .allocRd(rd),
        .resultWrite(resultWrite),
        .resultTag(resultTag),
        .resultData(result),
        .retire(commitValid),
        .readTag1(robReadTag1),
        .readTag2(robReadTag2),
        .allocTag(allocTag),
        .full(robFull),
        .headReady(headReady),
        .headRd(commitRd),
        .headTag(headTag),
        .headData(commitData),
        .robReadData1(robReadData1),
        .robReadData2(robReadData2)
    );

    execUnit i_execUnit (
        .clk(clk),
        .rst(rst),
        .load(accept),
        .aluOpIn(aluOp),
        .immIn(imm),
        .useImmIn(useImm),
        .tagIn(allocTag),
        .regData1(readData1),
        .regData2(readData2),
        .regTag1(readTag1),
        .regTag2(readTag2),
        .robReadData1(robReadData1),
        .robReadData2(robReadData2),
        .robReadTag1(robReadTag1),
        .robReadTag2(robReadTag2),
        .resultTag(resultTag),
        .result(result)
    );

    issueControl i_issueControl (
        .clk(clk),
        .rst(rst),
        .instValid(instValid),
        .flush(flush),
        .commitHold(commitHold),
        .robFull(robFull),
        .headReady(headReady),
        .writesRd(writesRd),
        .accept(accept),
        .renameEn(renameEn),
        .instStall(instStall),
        .resultWrite(resultWrite),
        .retire(commitValid)
    );

endmodule

/* reorderBuffer.sv */
`timescale 1ns/1ps

module reorderBuffer
    import coreDefs::*;
(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic alloc,
    input logic [regIdxWidth-1:0] allocRd,
    input logic resultWrite,
    input logic [tagWidth-1:0] resultTag,
    input logic [dataWidth-1:0] resultData,
    input logic retire,
    input logic [tagWidth-1:0] readTag1,
    input logic [tagWidth-1:0] readTag2,
    output logic [tagWidth-1:0] allocTag,
    output logic full,
    output logic headReady,
    output logic [regIdxWidth-1:0] headRd,
    output logic [tagWidth-1:0] headTag,
    output logic [dataWidth-1:0] headData,
    output logic [dataWidth-1:0] robReadData1,
    output logic [dataWidth-1:0] robReadData2
);

    logic [regIdxWidth-1:0] entryRd [robEntries];
    logic [dataWidth-1:0] entryData [robEntries];
    logic [robEntries-1:0] entryReady;
    logic [tagWidth-1:0] head;
    logic [tagWidth-1:0] tail;
    logic [tagWidth-1:0] count;
    logic [tagWidth-1:0] resultIdx;

    function automatic logic [tagWidth-1:0] nextPtr(input logic [tagWidth-1:0] ptr);
        return (ptr == tagWidth'(robEntries - 1)) ? '0 : ptr + tagWidth'(1);
    endfunction

    // a tag is its entry index plus one, leaving tag zero free.
    assign allocTag = tail + tagWidth'(1);
    assign headTag = head + tagWidth'(1);
    assign resultIdx = resultTag - tagWidth'(1);
    assign full = (count == tagWidth'(robEntries));
    assign headReady = (count != '0) && entryReady[head];
    assign headRd = entryRd[head];
    assign headData = entryData[head];

    assign robReadData1 = (readTag1 != '0) ? entryData[readTag1 - tagWidth'(1)] : '0;
    assign robReadData2 = (readTag2 != '0) ? entryData[readTag2 - tagWidth'(1)] : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            entryReady <= '0;
        end else if (flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            entryReady <= '0;
        end else begin
            if (alloc) begin
                entryReady[tail] <= 1'b0;
                tail <= nextPtr(tail);
            end
            if (resultWrite) begin
                entryReady[resultIdx] <= 1'b1;
            end
            if (retire) begin
                head <= nextPtr(head);
            end
            case ({alloc, retire})
                2'b10: count <= count + tagWidth'(1);
                2'b01: count <= count - tagWidth'(1);
                default: count <= count;
            endcase
        end
    end

    // payload, kept until the entry is handed out again.
    always_ff @(posedge clk) begin
        if (alloc) begin
            entryRd[tail] <= allocRd;
        end
        if (resultWrite) begin
            entryData[resultIdx] <= resultData;
        end
    end

    noRetireEmpty: assert property (@(posedge clk) disable iff (rst)
        retire |-> count != '0)
        else $error("retire from an empty reorder buffer");

    noAllocFull: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !full)
        else $error("allocation into a full reorder buffer");

endmodule

/* tb_renameCore.sv */
`timescale 1ns/1ps

module tb_renameCore
    import coreDefs::*;
();

    localparam int regCount = 2 ** regIdxWidth;
    localparam int drainLimit = 40;
    localparam int opAdd = 0;
    localparam int opSub = 1;
    localparam int opAnd = 2;
    localparam int opOr = 3;
    localparam int opXor = 4;
    localparam int opSlt = 5;
    localparam int opAddi = 6;
    localparam int opAndi = 7;
    localparam int opOri = 8;
    localparam int opXori = 9;
    localparam int opSlti = 10;

    logic clk;
    logic rst;
    logic instValid;
    logic [dataWidth-1:0] instWord;
    logic flush;
    logic commitHold;
    logic instStall;
    logic commitValid;
    logic [regIdxWidth-1:0] commitRd;
    logic [dataWidth-1:0] commitData;

    // the stimulus table holds one row per clock cycle.
    logic rowValid [$];
    logic [dataWidth-1:0] rowWord [$];
    logic rowFlush [$];
    logic rowHold [$];

    logic [dataWidth-1:0] specRegs [regCount];
    logic [dataWidth-1:0] archRegs [regCount];
    logic [regIdxWidth-1:0] expRd [$];
    logic [dataWidth-1:0] expData [$];
    int expCycle [$];
    int cycle = 0;
    int lastHoldCycle = -1;
    int prevCommitCycle = -1;
    int errors = 0;
    int commits = 0;
    int waited;

    renameCore i_renameCore (
        .clk(clk),
        .rst(rst),
        .instValid(instValid),
        .instWord(instWord),
        .flush(flush),
        .commitHold(commitHold),
        .instStall(instStall),
        .commitValid(commitValid),
        .commitRd(commitRd),
        .commitData(commitData)
    );

    always #20 clk = ~clk;

    // ******************************
    // table construction
    // ******************************
    function automatic logic [dataWidth-1:0] opWord(input int op, input int rd, input int rs1,
            input int rs2, input logic [11:0] imm12);
        instWord_u w;
        logic [2:0] f3;
        case (op)
            opAnd, opAndi: f3 = 3'b111;
            opOr, opOri: f3 = 3'b110;
            opXor, opXori: f3 = 3'b100;
            opSlt, opSlti: f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        if (op < opAddi) begin
            w.r.funct7 = (op == opSub) ? 7'b0100000 : 7'b0000000;
            w.r.rs2 = 5'(rs2);
            w.r.rs1 = 5'(rs1);
            w.r.funct3 = f3;
            w.r.rd = 5'(rd);
            w.r.opcode = opcodeReg;
        end else begin
            w.i.imm12 = imm12;
            w.i.rs1 = 5'(rs1);
            w.i.funct3 = f3;
            w.i.rd = 5'(rd);
            w.i.opcode = opcodeImm;
        end
        return w;
    endfunction

    task automatic addRow(input logic valid, input logic [dataWidth-1:0] word,
            input logic flushIn, input logic hold);
        rowValid.push_back(valid);
        rowWord.push_back(word);
        rowFlush.push_back(flushIn);
        rowHold.push_back(hold);
    endtask

    task automatic addInst(input logic [dataWidth-1:0] word, input logic hold);
        addRow(1'b1, word, 1'b0, hold);
    endtask

    task automatic addIdle(input int n, input logic hold);
        for (int k = 0; k < n; k++) begin
            addRow(1'b0, '0, 1'b0, hold);
        end
    endtask

    task automatic buildTable();
        logic [11:0] immA;
        logic [11:0] immB;
        logic [11:0] immC;
        immA = 12'($urandom);
        immB = 12'($urandom);
        immC = 12'($urandom);
        // sources still hold their reset value here.
        addInst(opWord(opAdd, 3, 4, 5, '0), 1'b0);
        addInst(opWord(opOri, 6, 7, 0, immA), 1'b0);
        // chain through all eleven operations with some operands still in flight.
        addInst(opWord(opAddi, 1, 0, 0, immA), 1'b0);
        addInst(opWord(opAddi, 2, 0, 0, immB), 1'b0);
        addInst(opWord(opAdd, 3, 1, 2, '0), 1'b0);
        addInst(opWord(opSub, 4, 3, 1, '0), 1'b0);
        addInst(opWord(opAnd, 5, 4, 2, '0), 1'b0);
        addInst(opWord(opOr, 6, 5, 3, '0), 1'b0);
        addInst(opWord(opXor, 7, 6, 1, '0), 1'b0);
        addInst(opWord(opSlt, 8, 7, 4, '0), 1'b0);
        addInst(opWord(opAndi, 9, 8, 0, immC), 1'b0);
        addInst(opWord(opOri, 10, 1, 0, immB), 1'b0);
        addInst(opWord(opXori, 11, 2, 0, immC), 1'b0);
        addInst(opWord(opSlti, 12, 1, 0, 12'h800), 1'b0);
        addIdle(1, 1'b0);
        addInst(opWord(opAdd, 13, 12, 10, '0), 1'b0);
        // writes to x0 and words with no destination.
        addInst(opWord(opAddi, 0, 1, 0, 12'h123), 1'b0);
        addInst(opWord(opAdd, 14, 0, 1, '0), 1'b0);
        addInst(32'h00002083, 1'b0);
        addInst(32'h000100ff, 1'b0);
        addInst(opWord(opAdd, 15, 1, 0, '0), 1'b0);
        addIdle(3, 1'b0);
        // nine rows arrive under hold but only seven entries fit.
        for (int k = 0; k < 9; k++) begin
            addInst(opWord(opAddi, 16 + k % 4, 16 + (k + 3) % 4, 0, 12'(k + 1)), 1'b1);
        end
        addIdle(2, 1'b1);
        addInst(opWord(opAdd, 20, 16, 17, '0), 1'b0);
        addInst(opWord(opAdd, 20, 18, 19, '0), 1'b0);
        addIdle(2, 1'b0);
        // flush with pending entries and a row in the flush cycle itself.
        addInst(opWord(opAddi, 21, 0, 0, 12'h007), 1'b0);
        addIdle(3, 1'b0);
        addInst(opWord(opAddi, 1, 0, 0, immB), 1'b1);
        addInst(opWord(opAddi, 22, 21, 0, 12'h005), 1'b1);
        addInst(opWord(opAdd, 21, 22, 1, '0), 1'b1);
        addRow(1'b1, opWord(opAddi, 23, 0, 0, 12'h001), 1'b1, 1'b1);
        addInst(opWord(opAdd, 24, 21, 1, '0), 1'b0);
        addInst(opWord(opAdd, 25, 22, 23, '0), 1'b0);
        addIdle(2, 1'b0);
        for (int k = 0; k < 24; k++) begin
            addRow(($urandom_range(3, 0) != 0),
                opWord($urandom_range(10, 0), $urandom_range(15, 1), $urandom_range(15, 0),
                    $urandom_range(15, 0), 12'($urandom)),
                1'b0, ($urandom_range(3, 0) == 0));
        end
    endtask

    // ******************************
    // golden model
    // ******************************
    task automatic modelAccept(input logic [dataWidth-1:0] word);
        instWord_u w;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] res;
        logic isSub;
        logic writes;
        logic [regIdxWidth-1:0] rd;
        w = word;
        a = specRegs[w.r.rs1];
        if (w.r.opcode == opcodeImm) begin
            b = {{(dataWidth - 12){w.i.imm12[11]}}, w.i.imm12};
        end else begin
            b = specRegs[w.r.rs2];
        end
        isSub = (w.r.opcode == opcodeReg) && (w.r.funct7 == 7'b0100000);
        writes = (w.r.opcode == opcodeReg) || (w.r.opcode == opcodeImm);
        if (w.r.opcode == opcodeReg && w.r.funct7 != 7'b0000000 &&
                !(isSub && w.r.funct3 == 3'b000)) begin
            writes = 1'b0;
        end
        case (w.r.funct3)
            3'b000: res = isSub ? a - b : a + b;
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b110: res = a | b;
            3'b111: res = a & b;
            default: begin
                res = '0;
                writes = 1'b0;
            end
        endcase
        rd = writes ? w.r.rd : '0;
        if (rd != '0) begin
            specRegs[rd] = res;
        end
        expRd.push_back(rd);
        expData.push_back(res);
        expCycle.push_back(cycle);
    endtask

    task automatic checkCommit();
        logic [regIdxWidth-1:0] rd;
        logic [dataWidth-1:0] data;
        int accCycle;
        commits++;
        assert (expRd.size() != 0)
        else begin
            errors++;
            $display("A result retired at %0t with no instruction outstanding", $time);
        end
        if (expRd.size() != 0) begin
            rd = expRd.pop_front();
            data = expData.pop_front();
            accCycle = expCycle.pop_front();
            assert (commitRd == rd)
            else begin
                errors++;
                $display("Mismatch at %0t: commitRd %0d, expected %0d", $time, commitRd, rd);
            end
            assert (rd == '0 || commitData == data)
            else begin
                errors++;
                $display("Mismatch at %0t: x%0d got %h, expected %h",
                    $time, rd, commitData, data);
            end
            assert (cycle - accCycle >= 2)
            else begin
                errors++;
                $display("Mismatch at %0t: retired %0d cycles after accept",
                    $time, cycle - accCycle);
            end
            // with no hold since acceptance and the head free in time, latency is exact.
            if (lastHoldCycle <= accCycle && prevCommitCycle <= accCycle + 1) begin
                assert (cycle == accCycle + 2)
                else begin
                    errors++;
                    $display("Mismatch at %0t: latency %0d, expected 2", $time, cycle - accCycle);
                end
            end
            if (rd != '0) begin
                archRegs[rd] = data;
            end
        end
        prevCommitCycle = cycle;
    endtask

    // called once per cycle at the falling edge, where outputs are settled.
    task automatic stepModel();
        cycle++;
        assert (instStall == (expRd.size() == robEntries))
        else begin
            errors++;
            $display("Mismatch at %0t: instStall %0b with %0d entries outstanding",
                $time, instStall, expRd.size());
        end
        if (commitValid) begin
            checkCommit();
        end
        if (flush || commitHold) begin
            lastHoldCycle = cycle;
        end
        if (flush) begin
            expRd.delete();
            expData.delete();
            expCycle.delete();
            specRegs = archRegs;
        end else if (instValid && !instStall) begin
            modelAccept(instWord);
        end
    endtask

    initial begin
        void'($urandom(32'h9a44d1c7));
        clk = 1'b0;
        rst = 1'b1;
        instValid = 1'b0;
        instWord = '0;
        flush = 1'b0;
        commitHold = 1'b0;
        for (int k = 0; k < regCount; k++) begin
            specRegs[k] = '0;
            archRegs[k] = '0;
        end
        buildTable();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!instStall && !commitValid)
        else begin
            errors++;
            $display("Outputs were not idle after reset");
        end
        for (int i = 0; i < rowValid.size(); i++) begin
            @(posedge clk);
            #1;
            instValid = rowValid[i];
            instWord = rowWord[i];
            flush = rowFlush[i];
            commitHold = rowHold[i];
            @(negedge clk);
            stepModel();
        end
        @(posedge clk);
        #1;
        instValid = 1'b0;
        flush = 1'b0;
        commitHold = 1'b0;
        waited = 0;
        while (expRd.size() != 0 && waited < drainLimit) begin
            @(negedge clk);
            stepModel();
            waited++;
        end
        assert (expRd.size() == 0)
        else begin
            errors++;
            $display("Retire stream stalled with %0d results outstanding", expRd.size());
        end
        repeat (4) begin
            @(negedge clk);
            stepModel();
        end
        $display("Errors: %0d, results checked: %0d", errors, commits);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
